/* all.f */
+incdir+verilog
verilog/uart_rx_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_rx_channel.sv
verilog/rx_collector.sv
verilog/multi_uart_rx.sv
bench/multi_uart_rx_props.sv
bench/multi_uart_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the multi-channel uart receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module multi_uart_rx_tb \
  -f all.f --Mdir obj_dir -o sim_multi_uart_rx

status=0
./obj_dir/sim_multi_uart_rx > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

/* bench/multi_uart_rx_tb.sv */
// --------------------------------------------------
// multi-channel uart receiver testbench
// drives serial frames from a stimulus table and
// checks each collected frame against expected values
// --------------------------------------------------
`timescale 1ns/1ps
`include "uart_rx_consts.svh"
`default_nettype none

module multi_uart_rx_tb;
  import uart_rx_pkg::*;

  localparam int NUM_ROWS   = 17;
  localparam int BIT_CLKS   = 2 * `UART_OVERSAMPLE;  // baud_div of 1
  localparam int FRAME_LIM  = 400;                   // clocks allowed per frame
  localparam int RESET_CLKS = 10;

  typedef enum logic [1:0] {
    K_FRAME,   // one frame on one line
    K_ALL,     // same frame on every line at once
    K_GLITCH   // one-clock low pulse on an idle line
  } row_kind_t;

  typedef struct packed {
    row_kind_t  kind;
    line_cfg_t  cfg;
    ch_idx_t    ch;
    logic [7:0] data;
    logic       bad_par;
    logic       bad_stop;
    logic [7:0] exp_data;
    logic       exp_perr;
    logic       exp_ferr;
  } row_t;

  logic                    clk;
  logic                    aresetn;
  logic [`UART_DIV_W-1:0]  baud_div;
  line_cfg_t               cfg;
  logic [`UART_NUM_CH-1:0] serial_in;
  logic                    rx_valid;
  rx_out_t                 rx_out;

  row_t        rows [NUM_ROWS];
  rx_out_t     got_q [$];   // frames seen on the output
  logic [31:0] rng_state;
  int          err_count;
  int          check_count;

  multi_uart_rx uut (
    .clk       (clk),
    .aresetn   (aresetn),
    .baud_div  (baud_div),
    .cfg       (cfg),
    .serial_in (serial_in),
    .rx_valid  (rx_valid),
    .rx_out    (rx_out)
  );

  bind multi_uart_rx multi_uart_rx_props u_props (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_div    (baud_div),
    .tick        (tick),
    .frame_valid (frame_valid),
    .rx_valid    (rx_valid),
    .rx_out      (rx_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // output monitor, sampled mid-cycle
  always @(negedge clk)
  begin
    if (aresetn && rx_valid)
      got_q.push_back(rx_out);
  end

  initial
  begin
    repeat (NUM_ROWS * 500 + RESET_CLKS) @(posedge clk);
    $display("watchdog expired before the last row finished");
    $display("TB FAILED");
    $finish;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] rand_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  function automatic string kind_label(input row_kind_t k);
    case (k)
      K_ALL:    return "all";
      K_GLITCH: return "glitch";
      default:  return "frame";
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic add_row(input int idx, input row_kind_t kind, input logic [2:0] c,
                         input int ch, input logic [7:0] d, input logic bp, input logic bs);
    row_t r;
    r.kind     = kind;
    r.cfg      = line_cfg_t'(c);
    r.ch       = ch_idx_t'(ch);
    r.data     = d;
    r.bad_par  = bp;
    r.bad_stop = bs;
    r.exp_data = r.cfg.bit8 ? d : {1'b0, d[6:0]};  // seven-bit mode clears the top bit
    r.exp_perr = r.cfg.parity_en & bp;
    r.exp_ferr = bs;
    rows[idx]  = r;
  endtask

  // cfg columns are {bit8, parity_en, odd_parity}
  task automatic load_table();
    add_row(0,  K_FRAME,  3'b100, 0, 8'h3c,       1'b0, 1'b0);
    add_row(1,  K_FRAME,  3'b100, 1, 8'hc3,       1'b0, 1'b0);
    add_row(2,  K_FRAME,  3'b100, 2, rand_byte(), 1'b0, 1'b0);
    add_row(3,  K_FRAME,  3'b100, 3, 8'h81,       1'b0, 1'b0);
    add_row(4,  K_FRAME,  3'b000, 1, 8'hff,       1'b0, 1'b0);
    add_row(5,  K_FRAME,  3'b010, 2, 8'hd5,       1'b0, 1'b0);
    add_row(6,  K_FRAME,  3'b011, 3, rand_byte(), 1'b0, 1'b0);
    add_row(7,  K_FRAME,  3'b110, 0, 8'h5a,       1'b0, 1'b0);
    add_row(8,  K_FRAME,  3'b111, 1, 8'h5b,       1'b0, 1'b0);
    add_row(9,  K_FRAME,  3'b110, 2, 8'h77,       1'b1, 1'b0);
    add_row(10, K_FRAME,  3'b111, 3, rand_byte(), 1'b1, 1'b0);
    add_row(11, K_FRAME,  3'b011, 0, 8'h2e,       1'b1, 1'b0);
    add_row(12, K_FRAME,  3'b100, 1, 8'h96,       1'b0, 1'b1);
    add_row(13, K_FRAME,  3'b100, 1, 8'h69,       1'b0, 1'b0);  // recovery after low stop
    add_row(14, K_FRAME,  3'b101, 3, 8'h00,       1'b1, 1'b0);  // parity off, bit ignored
    add_row(15, K_ALL,    3'b110, 0, rand_byte(), 1'b0, 1'b0);
    add_row(16, K_GLITCH, 3'b100, 2, 8'h00,       1'b0, 1'b0);
  endtask

  // --------------------------------------------------
  // serial line driver
  // --------------------------------------------------
  task automatic drive_bit(input logic [3:0] lines, input logic b);
    @(posedge clk);
    #1;
    for (int i = 0; i < `UART_NUM_CH; i++)
    begin
      if (lines[i])
        serial_in[i] = b;
    end
    repeat (BIT_CLKS - 1) @(posedge clk);
  endtask

  task automatic send_frame(input logic [3:0] lines, input line_cfg_t c, input logic [7:0] d,
                            input logic bp, input logic bs);
    int   nbits;
    logic par;
    nbits = c.bit8 ? 8 : 7;
    par   = c.odd_parity;  // odd parity starts the count at one
    drive_bit(lines, 1'b0);
    for (int i = 0; i < nbits; i++)
    begin
      drive_bit(lines, d[i]);
      par = par ^ d[i];
    end
    if (c.parity_en)
      drive_bit(lines, par ^ bp);
    drive_bit(lines, ~bs);
    drive_bit(lines, 1'b1);  // back to idle
  endtask

  task automatic wait_frames(input int n, output logic seen);
    int cnt;
    cnt = 0;
    while (got_q.size() < n && cnt < FRAME_LIM)
    begin
      @(posedge clk);
      cnt++;
    end
    seen = (got_q.size() >= n);
  endtask

  task automatic run_row(input int idx);
    row_t       r;
    logic       arrived;
    int         errs_before;
    int         n_exp;
    logic [3:0] lines;
    logic [3:0] seen_ch;
    rx_out_t    o;
    r           = rows[idx];
    errs_before = err_count;
    n_exp       = (r.kind == K_ALL) ? 4 : 1;
    lines       = (r.kind == K_ALL) ? 4'hf : (4'b0001 << r.ch);
    @(posedge clk);
    #1;
    cfg = r.cfg;
    got_q.delete();
    if (r.kind == K_GLITCH)
    begin
      serial_in[r.ch] = 1'b0;
      @(posedge clk);
      #1;
      serial_in[r.ch] = 1'b1;
      wait_frames(1, arrived);
      if (arrived)
      begin
        err_count++;
        $display("row %0d: glitch on channel %0d produced a frame", idx, r.ch);
      end
    end
    else
    begin
      fork
        send_frame(lines, r.cfg, r.data, r.bad_par, r.bad_stop);
        wait_frames(n_exp, arrived);
      join
      repeat (2 * BIT_CLKS) @(posedge clk);  // idle gap, catches stray frames
      if (!arrived)
      begin
        err_count++;
        $display("row %0d: no frame arrived within %0d clocks", idx, FRAME_LIM);
      end
      else if (got_q.size() != n_exp)
      begin
        err_count++;
        $display("row %0d: %0d frames arrived, %0d expected", idx, got_q.size(), n_exp);
      end
      else
      begin
        seen_ch = '0;
        foreach (got_q[k])
        begin
          o = got_q[k];
          seen_ch[o.channel] = 1'b1;
          if (r.kind == K_FRAME)
            check("rx_out.channel", 32'(o.channel), 32'(r.ch));
          check("rx_out.frame.data", 32'(o.frame.data), 32'(r.exp_data));
          check("rx_out.frame.parity_err", 32'(o.frame.parity_err), 32'(r.exp_perr));
          check("rx_out.frame.framing_err", 32'(o.frame.framing_err), 32'(r.exp_ferr));
        end
        if (r.kind == K_ALL)
          check("channels seen", 32'(seen_ch), 32'h0000_000f);
      end
    end
    $display("row %0d %s ch %0d data 0x%02h: %s", idx, kind_label(r.kind), r.ch, r.data,
             (err_count == errs_before) ? "ok" : "error");
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin
    aresetn     = 1'b0;
    baud_div    = 16'd1;
    cfg         = '0;
    serial_in   = '1;  // idle lines
    err_count   = 0;
    check_count = 0;
    rng_state   = 32'ha981_ac5d;
    load_table();
    repeat (RESET_CLKS) @(posedge clk);
    #1;
    aresetn = 1'b1;
    repeat (4 * BIT_CLKS) @(posedge clk);
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);
    $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, check_count, err_count);
    if (err_count == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/multi_uart_rx_props.sv */
// --------------------------------------------------
// receiver top assertions
// output strobe, drain latency and tick spacing
// --------------------------------------------------
`timescale 1ns/1ps
`include "uart_rx_consts.svh"
`default_nettype none

module multi_uart_rx_props (
  input logic                    clk,
  input logic                    aresetn,
  input logic [`UART_DIV_W-1:0]  baud_div,
  input logic                    tick,
  input logic [`UART_NUM_CH-1:0] frame_valid,
  input logic                    rx_valid,
  input uart_rx_pkg::rx_out_t    rx_out
);
  import uart_rx_pkg::*;

  logic [2:0] age [`UART_NUM_CH];  // cycles a strobed frame has been waiting

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      for (int i = 0; i < `UART_NUM_CH; i++)
        age[i] <= 3'd0;
    end
    else
    begin
      for (int i = 0; i < `UART_NUM_CH; i++)
      begin
        if (frame_valid[i])
          age[i] <= 3'd1;
        else if (rx_valid && rx_out.channel == ch_idx_t'(i))
          age[i] <= 3'd0;
        else if (age[i] != 3'd0 && age[i] != 3'd7)
          age[i] <= age[i] + 3'd1;  // saturates
      end
    end
  end

  for (genvar i = 0; i < `UART_NUM_CH; i++)
  begin : g_ch
    a_strobe_single: assert property (@(posedge clk) disable iff (!aresetn)
      frame_valid[i] |=> !frame_valid[i])
      else $error("frame_valid high two cycles on channel %0d", i);

    a_drain: assert property (@(posedge clk) disable iff (!aresetn) age[i] <= 3'd4)
      else $error("channel %0d frame waited more than four cycles", i);
  end

  a_valid_known: assert property (@(posedge clk) disable iff (!aresetn) !$isunknown(rx_valid))
    else $error("rx_valid unknown");

  a_tick_single: assert property (@(posedge clk) disable iff (!aresetn)
    (baud_div != '0 && tick) |=> !tick)
    else $error("tick high on consecutive cycles");

endmodule

`default_nettype wire

/* verilog/multi_uart_rx.sv */
// --------------------------------------------------
// multi-channel uart receiver top
// shared tick generator, receive channels and the
// output collector
// --------------------------------------------------
`timescale 1ns/1ps
`include "uart_rx_consts.svh"
`default_nettype none

module multi_uart_rx (
  input  logic                    clk,
  input  logic                    aresetn,
  input  logic [`UART_DIV_W-1:0]  baud_div,
  input  uart_rx_pkg::line_cfg_t  cfg,
  input  logic [`UART_NUM_CH-1:0] serial_in,
  output logic                    rx_valid,
  output uart_rx_pkg::rx_out_t    rx_out
);
  import uart_rx_pkg::*;

  logic                           tick;
  logic [`UART_NUM_CH-1:0]        frame_valid;
  rx_frame_t [`UART_NUM_CH-1:0]   frame;

  baud_tick_gen u_tick (
    .clk      (clk),
    .aresetn  (aresetn),
    .baud_div (baud_div),
    .tick     (tick)
  );

  for (genvar g = 0; g < `UART_NUM_CH; g++)
  begin : g_ch
    uart_rx_channel u_ch (
      .clk         (clk),
      .aresetn     (aresetn),
      .tick        (tick),
      .cfg         (cfg),
      .serial_in   (serial_in[g]),
      .frame_valid (frame_valid[g]),
      .frame       (frame[g])
    );
  end

  rx_collector u_coll (
    .clk         (clk),
    .aresetn     (aresetn),
    .frame_valid (frame_valid),
    .frame       (frame),
    .rx_valid    (rx_valid),
    .rx_out      (rx_out)
  );

endmodule

`default_nettype wire

/* verilog/rx_collector.sv */
// --------------------------------------------------
// frame collector
// one pending slot per channel, drained round-robin
// onto a single output strobe
// --------------------------------------------------
`timescale 1ns/1ps
`include "uart_rx_consts.svh"
`default_nettype none

module rx_collector (
  input  logic                                     clk,
  input  logic                                     aresetn,
  input  logic [`UART_NUM_CH-1:0]                  frame_valid,
  input  uart_rx_pkg::rx_frame_t [`UART_NUM_CH-1:0] frame,
  output logic                                     rx_valid,
  output uart_rx_pkg::rx_out_t                     rx_out
);
  import uart_rx_pkg::*;

  logic [`UART_NUM_CH-1:0] pending;
  rx_frame_t               frame_q [`UART_NUM_CH];
  ch_idx_t                 last_ch;   // channel served most recently
  ch_idx_t                 pick;
  logic                    any_pend;

  // first pending channel after last_ch, wrapping round
  always_comb
  begin : rr_pick
    int idx;
    pick     = last_ch;
    any_pend = 1'b0;
    for (int k = 1; k <= `UART_NUM_CH; k++)
    begin
      idx = (int'(last_ch) + k) % `UART_NUM_CH;
      if (pending[idx] && !any_pend)
      begin
        pick     = ch_idx_t'(idx);
        any_pend = 1'b1;
      end
    end
  end

  assign rx_valid = any_pend;
  assign rx_out   = {frame_q[pick], pick};

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      pending <= '0;
      last_ch <= '0;
    end
    else
    begin
      for (int i = 0; i < `UART_NUM_CH; i++)
      begin
        if (frame_valid[i])
          pending[i] <= 1'b1;
        else if (any_pend && pick == ch_idx_t'(i))
          pending[i] <= 1'b0;  // emitted this cycle
      end
      if (any_pend)
        last_ch <= pick;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `UART_NUM_CH; i++)
    begin
      if (frame_valid[i])
        frame_q[i] <= frame[i];
    end
  end

endmodule

`default_nettype wire

/* verilog/uart_rx_channel.sv */
// --------------------------------------------------
// single uart receive channel
// majority filter, start detect at mid-bit, data and
// parity shift-in, parity and framing checks
// --------------------------------------------------
`timescale 1ns/1ps
`include "uart_rx_consts.svh"
`default_nettype none

module uart_rx_channel (
  input  logic                   clk,
  input  logic                   aresetn,
  input  logic                   tick,
  input  uart_rx_pkg::line_cfg_t cfg,
  input  logic                   serial_in,
  output logic                   frame_valid,
  output uart_rx_pkg::rx_frame_t frame
);
  import uart_rx_pkg::*;

  localparam logic [3:0] MID_CNT  = 4'(`UART_MID_SAMPLE);
  localparam logic [3:0] LAST_CNT = 4'(`UART_OVERSAMPLE - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_STOP,
    ST_WAIT
  } rx_state_t;

  rx_state_t   state;
  logic [2:0]  samples;     // newest sample in bit 2
  logic        rx_filt;
  logic [3:0]  samp_cnt;    // ticks within the current bit
  logic [3:0]  bit_cnt;     // data and parity bits taken so far
  logic [3:0]  last_bit;    // index of the final bit, also the insert point
  frame_word_u shift_q;
  logic        par_acc;     // running xor of sampled bits
  logic        start_ok;
  logic        bit_centre;
  logic        stop_hit;

  // shift the word right below the insert point and drop the new bit at top
  function automatic frame_word_u shift_in(frame_word_u w, logic [3:0] top, logic b);
    logic [8:0] src;
    logic [8:0] res;
    src = w;
    res = w;
    for (int i = 0; i < 8; i++)
    begin
      if (i < int'(top))
        res[i] = src[i+1];
    end
    res[top] = b;
    return res;
  endfunction

  // --------------------------------------------------
  // line filter
  // --------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      samples <= 3'b111;  // idle line
    else if (tick)
      samples <= {serial_in, samples[2:1]};
  end

  // two out of three vote
  assign rx_filt = (samples[0] & samples[1]) | (samples[0] & samples[2]) |
                   (samples[1] & samples[2]);

  assign start_ok   = (state == ST_IDLE) && !rx_filt && (samp_cnt == MID_CNT);
  assign bit_centre = (samp_cnt == LAST_CNT);
  assign stop_hit   = tick && (state == ST_STOP) && bit_centre;

  // --------------------------------------------------
  // sample counter and state machine
  // --------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      samp_cnt <= '0;
    else if (tick)
    begin
      // held at zero while idle-high, realigned on start confirm
      if ((state == ST_IDLE && (rx_filt || samp_cnt == MID_CNT)) || state == ST_WAIT)
        samp_cnt <= '0;
      else
        samp_cnt <= samp_cnt + 4'd1;  // wraps at the bit centre
    end
  end

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state    <= ST_IDLE;
      bit_cnt  <= '0;
      last_bit <= '0;
    end
    else if (tick)
    begin
      case (state)
        ST_IDLE:
        begin
          if (start_ok)
          begin
            state    <= ST_DATA;
            bit_cnt  <= '0;
            last_bit <= 4'd6 + 4'(cfg.bit8) + 4'(cfg.parity_en);
          end
        end
        ST_DATA:
        begin
          if (bit_centre)
          begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == last_bit)
              state <= ST_STOP;
          end
        end
        ST_STOP:
        begin
          if (bit_centre)
            state <= ST_WAIT;
        end
        ST_WAIT:
        begin
          if (rx_filt)
            state <= ST_IDLE;  // low stop bit holds us here until the line frees
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // shift register, parity and frame output
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (tick)
    begin
      if (start_ok)
      begin
        shift_q <= '0;
        par_acc <= 1'b0;
      end
      else if (state == ST_DATA && bit_centre)
      begin
        shift_q <= shift_in(shift_q, last_bit, rx_filt);
        par_acc <= par_acc ^ rx_filt;
      end
    end
  end

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      frame_valid <= 1'b0;
    else
      frame_valid <= stop_hit;
  end

  always_ff @(posedge clk)
  begin
    if (stop_hit)
    begin
      frame.data        <= cfg.bit8 ? shift_q.w8.data : {1'b0, shift_q.w7.data};
      frame.parity_err  <= cfg.parity_en & (par_acc ^ cfg.odd_parity);
      frame.framing_err <= ~rx_filt;
    end
  end

endmodule

`default_nettype wire

/* verilog/baud_tick_gen.sv */
// --------------------------------------------------
// oversampling tick generator
// one-cycle tick every baud_div+1 clocks
// --------------------------------------------------
`timescale 1ns/1ps
`include "uart_rx_consts.svh"
`default_nettype none

module baud_tick_gen (
  input  logic                   clk,
  input  logic                   aresetn,
  input  logic [`UART_DIV_W-1:0] baud_div,
  output logic                   tick
);

  logic [`UART_DIV_W-1:0] div_cnt;

  // down-counter, a new divisor is picked up at the next reload
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end
    else if (div_cnt == '0)
    begin
      div_cnt <= baud_div;
      tick    <= 1'b1;
    end
    else
    begin
      div_cnt <= div_cnt - 1'b1;
      tick    <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/uart_rx_pkg.sv */
// --------------------------------------------------
// uart receiver types
// line configuration, received frame, collector
// output word and the shift register word views
// --------------------------------------------------
`default_nettype none

package uart_rx_pkg;

  // line format, shared by all channels
  typedef struct packed {
    logic bit8;        // eight data bits, else seven
    logic parity_en;   // parity bit after the data
    logic odd_parity;  // odd, else even
  } line_cfg_t;

  // --------------------------------------------------
  // shift register word, read per data length
  // --------------------------------------------------
  typedef struct packed {
    logic       parity;
    logic [7:0] data;
  } frame8_t;

  typedef struct packed {
    logic       spare;   // never written in seven-bit mode
    logic       parity;
    logic [6:0] data;
  } frame7_t;

  typedef union packed {
    frame8_t w8;
    frame7_t w7;
  } frame_word_u;

  typedef logic [1:0] ch_idx_t;

  typedef struct packed {
    logic [7:0] data;         // bit 7 zero in seven-bit mode
    logic       parity_err;
    logic       framing_err;  // stop bit sampled low
  } rx_frame_t;

  typedef struct packed {
    rx_frame_t frame;
    ch_idx_t   channel;
  } rx_out_t;

endpackage

`default_nettype wire

/* verilog/uart_rx_consts.svh */
// --------------------------------------------------
// uart receiver constants
// oversampling ratio, start-bit confirm point,
// channel count and baud divisor width
// --------------------------------------------------
`ifndef UART_RX_CONSTS_SVH
`define UART_RX_CONSTS_SVH

`default_nettype none

// ticks per serial bit
`define UART_OVERSAMPLE 16

// tick count at which a start bit is taken as real
`define UART_MID_SAMPLE 8

`define UART_NUM_CH 4      // receive channels
`define UART_DIV_W  16     // baud divisor width

`default_nettype wire

`endif
